/* list.f */
rtl/rv_isa_pkg.sv
rtl/rv_bus_pkg.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/int_alu.sv
rtl/lsu.sv
rtl/core_seq.sv
rtl/rv_core_top.sv
tests/tb_clock.sv
tests/tb_mem_model.sv
tests/tb_rv_core.sv

/* rtl/core_seq.sv */
`timescale 1ns/1ns

module core_seq
    import rv_bus_pkg::*;
#(
    parameter xlen_t RESET_PC = '0
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        inst_req,
    output xlen_t       inst_addr,
    input  logic [31:0] inst_data,
    input  logic        inst_ack,
    output logic [31:0] inst,
    input  logic        is_mem,
    input  logic        illegal,
    output logic        lsu_start,
    input  logic        lsu_done,
    output logic        wb_en,
    input  logic        writes_rd,
    output logic        retire,
    output logic        halted
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_ACK_LOW,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } seq_state_t;

    seq_state_t state;
    xlen_t      pc;

    assign inst_addr = pc;
    assign lsu_start = (state == S_EXEC) && is_mem && !illegal; // one cycle
    assign wb_en     = (state == S_WB) && writes_rd;
    assign retire    = (state == S_WB);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_ACK_LOW; // first fetch once ack is low
            pc       <= RESET_PC;
            inst_req <= 1'b0;
            halted   <= 1'b0;
        end else begin
            case (state)
                S_ACK_LOW: begin
                    if (!inst_ack) begin
                        inst_req <= 1'b1;
                        state    <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (inst_ack) begin
                        inst_req <= 1'b0;
                        state    <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (illegal) begin
                        halted <= 1'b1; // sticky
                        state  <= S_HALT;
                    end else if (is_mem) begin
                        state <= S_MEM;
                    end else begin
                        state <= S_WB;
                    end
                end
                S_MEM:   if (lsu_done) state <= S_WB;
                S_WB: begin
                    pc    <= pc + 64'd4;
                    state <= S_ACK_LOW;
                end
                S_HALT:  state <= S_HALT;
                default: state <= S_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && inst_ack) inst <= inst_data; // instruction register
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        inst_req && !inst_ack |=> $stable(inst_addr))
        else $error("inst_addr changed during a fetch");

endmodule

/* rtl/inst_decode.sv */
`timescale 1ns/1ns

module inst_decode
    import rv_isa_pkg::*, rv_bus_pkg::*;
(
    input  logic [31:0] inst,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    output reg_addr_t   rd_addr,
    output xlen_t       imm,
    output logic        use_imm,
    output alu_op_t     alu_op,
    output wb_ext_t     wb_ext,
    output logic        is_load,
    output logic        is_store,
    output logic        writes_rd,
    output mem_size_t   mem_size,
    output logic        load_unsigned,
    output logic        illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;
    alu_op_t    f3_op;
    logic       f3_ok;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rd_addr  = inst[11:7];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};

    // funct3 to alu op for the register and immediate groups
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            F3_ADD_SUB: f3_op = ALU_ADD;
            F3_XOR:     f3_op = ALU_XOR;
            F3_OR:      f3_op = ALU_OR;
            F3_AND:     f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0; // shifts and compares not supported
            end
        endcase
    end

    always_comb begin
        imm           = imm_i;
        use_imm       = 1'b0;
        alu_op        = ALU_ADD;
        wb_ext        = WB_FULL;
        is_load       = 1'b0;
        is_store      = 1'b0;
        writes_rd     = 1'b0;
        mem_size      = SIZE_D;
        load_unsigned = 1'b0;
        illegal       = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_32: begin
                writes_rd = 1'b1;
                alu_op    = f3_op;
                if (opcode == OPC_OP_32) begin
                    wb_ext = WB_SEXT_W;
                    if (funct3 != F3_ADD_SUB) illegal = 1'b1; // only addw / subw
                end
                if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) alu_op = ALU_SUB;
                else if (funct7 != F7_BASE || !f3_ok) illegal = 1'b1;
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                alu_op    = f3_op;
                illegal   = !f3_ok;
                if (opcode == OPC_OP_IMM_32) begin
                    wb_ext = WB_SEXT_W;
                    if (funct3 != F3_ADD_SUB) illegal = 1'b1; // addiw only
                end
            end
            OPC_LUI: begin
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
            end
            OPC_LOAD: begin
                writes_rd = 1'b1;
                use_imm   = 1'b1;
                is_load   = 1'b1;
                case (funct3)
                    F3_MEM_D: mem_size = SIZE_D;
                    F3_MEM_W: begin
                        mem_size = SIZE_W;
                        wb_ext   = WB_SEXT_W;
                    end
                    F3_MEM_WU: begin
                        mem_size      = SIZE_W;
                        wb_ext        = WB_ZEXT_W;
                        load_unsigned = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OPC_STORE: begin
                use_imm  = 1'b1;
                imm      = imm_s;
                is_store = 1'b1;
                case (funct3)
                    F3_MEM_B: mem_size = SIZE_B;
                    F3_MEM_W: mem_size = SIZE_W;
                    F3_MEM_D: mem_size = SIZE_D;
                    default:  illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* rtl/int_alu.sv */
`timescale 1ns/1ns

module int_alu
    import rv_isa_pkg::*, rv_bus_pkg::*;
(
    input  xlen_t   a,
    input  xlen_t   b,
    input  alu_op_t op,
    output xlen_t   result
);

    xlen_t sum;
    xlen_t diff;

    assign sum  = a + b; // also the load / store address
    assign diff = a - b;

    always_comb begin
        case (op)
            ALU_ADD:    result = sum;
            ALU_SUB:    result = diff;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_PASS_B: result = b; // lui
            default:    result = sum;
        endcase
    end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/1ns

module lsu
    import rv_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       is_store,
    input  mem_size_t  size,
    input  xlen_t      addr,
    input  xlen_t      store_data,
    output logic       done,
    output xlen_t      load_data,
    output logic       mem_req,
    output logic       mem_we,
    output xlen_t      mem_addr,
    output xlen_t      mem_wdata,
    output byte_mask_t mem_wmask,
    input  logic       mem_ack,
    input  xlen_t      mem_rdata
);

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_REQ,
        LSU_RELEASE
    } lsu_state_t;

    lsu_state_t state;
    byte_mask_t mask;
    logic [2:0] off_q;
    logic [5:0] lane_shift;

    assign lane_shift = {addr[2:0], 3'b000};
    assign mem_req    = (state == LSU_REQ);

    always_comb begin
        case (size)
            SIZE_B:  mask = byte_mask_t'(8'h01) << addr[2:0];
            SIZE_W:  mask = byte_mask_t'(8'h0f) << addr[2:0];
            default: mask = 8'hff;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LSU_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                LSU_IDLE:    if (start) state <= LSU_REQ;
                LSU_REQ:     if (mem_ack) state <= LSU_RELEASE; // drop req
                LSU_RELEASE: begin
                    if (!mem_ack) begin
                        state <= LSU_IDLE;
                        done  <= 1'b1;
                    end
                end
                default:     state <= LSU_IDLE;
            endcase
        end
    end

    // request payload held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == LSU_IDLE && start) begin
            mem_addr  <= {addr[63:3], 3'b000};
            mem_we    <= is_store;
            mem_wdata <= store_data << lane_shift;
            mem_wmask <= is_store ? mask : '0;
            off_q     <= addr[2:0];
        end
        if (state == LSU_REQ && mem_ack && !mem_we) begin
            load_data <= mem_rdata >> {off_q, 3'b000}; // back to lane zero
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack");

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ns

module reg_file
    import rv_isa_pkg::*, rv_bus_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wb_en,
    input  reg_addr_t rd_addr,
    input  xlen_t     wb_data,
    input  wb_ext_t   wb_ext,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  reg_addr_t dbg_addr,
    output xlen_t     dbg_data
);

    localparam int IDX_W = $clog2(REG_COUNT);

    xlen_t            regs [REG_COUNT];
    xlen_t            ext_data;
    logic [IDX_W-1:0] wr_idx;

    function automatic xlen_t read_reg(input reg_addr_t addr);
        logic [IDX_W-1:0] idx;
        idx = addr[IDX_W-1:0]; // upper index bits ignored for small files
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    assign wr_idx = rd_addr[IDX_W-1:0];

    always_comb begin
        case (wb_ext)
            WB_SEXT_W: ext_data = {{32{wb_data[31]}}, wb_data[31:0]};
            WB_ZEXT_W: ext_data = {32'b0, wb_data[31:0]};
            default:   ext_data = wb_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wr_idx != '0) begin // x0 stays zero
            regs[wr_idx] <= ext_data;
        end
    end

    assign rs1_data = read_reg(rs1_addr);
    assign rs2_data = read_reg(rs2_addr);
    assign dbg_data = read_reg(dbg_addr); // debug view of the array

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("register entry zero holds a nonzero value");

endmodule

/* rtl/rv_bus_pkg.sv */
package rv_bus_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;

    typedef logic [XLEN/8-1:0] byte_mask_t; // one bit per byte lane

    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_W,
        SIZE_D
    } mem_size_t;

endpackage

/* rtl/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top
    import rv_isa_pkg::*, rv_bus_pkg::*;
#(
    parameter int    REG_COUNT = 32,
    parameter xlen_t RESET_PC  = '0
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        inst_req,
    output xlen_t       inst_addr,
    input  logic [31:0] inst_data,
    input  logic        inst_ack,
    output logic        mem_req,
    output logic        mem_we,
    output xlen_t       mem_addr,
    output xlen_t       mem_wdata,
    output byte_mask_t  mem_wmask,
    input  logic        mem_ack,
    input  xlen_t       mem_rdata,
    input  reg_addr_t   dbg_addr,
    output xlen_t       dbg_data,
    output logic        retire,
    output logic        halted
);

    logic [31:0] inst;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    reg_addr_t   rd_addr;
    xlen_t       imm;
    logic        use_imm;
    alu_op_t     alu_op;
    wb_ext_t     dec_wb_ext;
    logic        is_load;
    logic        is_store;
    logic        writes_rd;
    mem_size_t   mem_size;
    logic        illegal;
    logic        lsu_start;
    logic        lsu_done;
    logic        wb_en;
    xlen_t       rs1_data;
    xlen_t       rs2_data;
    xlen_t       alu_b;
    xlen_t       alu_result;
    xlen_t       load_data;
    xlen_t       wb_data;

    assign alu_b   = use_imm ? imm : rs2_data; // operand mux
    assign wb_data = is_load ? load_data : alu_result;

    core_seq #(
        .RESET_PC (RESET_PC)
    ) u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_req  (inst_req),
        .inst_addr (inst_addr),
        .inst_data (inst_data),
        .inst_ack  (inst_ack),
        .inst      (inst),
        .is_mem    (is_load | is_store),
        .illegal   (illegal),
        .lsu_start (lsu_start),
        .lsu_done  (lsu_done),
        .wb_en     (wb_en),
        .writes_rd (writes_rd),
        .retire    (retire),
        .halted    (halted)
    );

    inst_decode u_dec (
        .inst          (inst),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rd_addr       (rd_addr),
        .imm           (imm),
        .use_imm       (use_imm),
        .alu_op        (alu_op),
        .wb_ext        (dec_wb_ext),
        .is_load       (is_load),
        .is_store      (is_store),
        .writes_rd     (writes_rd),
        .mem_size      (mem_size),
        .load_unsigned (),
        .illegal       (illegal)
    );

    reg_file #(
        .REG_COUNT (REG_COUNT)
    ) u_rf (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_en    (wb_en),
        .rd_addr  (rd_addr),
        .wb_data  (wb_data),
        .wb_ext   (dec_wb_ext),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    int_alu u_alu (
        .a      (rs1_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    lsu u_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (lsu_start),
        .is_store   (is_store),
        .size       (mem_size),
        .addr       (alu_result), // rs1 + offset
        .store_data (rs2_data),
        .done       (lsu_done),
        .load_data  (load_data),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wmask  (mem_wmask),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [4:0] reg_addr_t;

    // major opcodes
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_MEM_B  = 3'b000; // sb
    localparam logic [2:0] F3_MEM_W  = 3'b010; // lw / sw
    localparam logic [2:0] F3_MEM_D  = 3'b011; // ld / sd
    localparam logic [2:0] F3_MEM_WU = 3'b110; // lwu

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    // how the write-back value is widened before it lands in the register file
    typedef enum logic [1:0] {
        WB_FULL,
        WB_SEXT_W,
        WB_ZEXT_W
    } wb_ext_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f list.f -o sim_tb_rv_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 16
) (
    input  logic rerun,
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset at start, and again on each rising rerun
    initial begin
        rst_n = 1'b0;
        forever begin
            repeat (RESET_CYCLES) @(negedge clk);
            rst_n = 1'b1;
            @(posedge rerun);
            @(negedge clk);
            rst_n = 1'b0;
        end
    end

endmodule

/* tests/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        slow,
    input  logic        inst_req,
    input  logic [63:0] inst_addr,
    output logic [31:0] inst_data,
    output logic        inst_ack,
    input  logic        mem_req,
    input  logic        mem_we,
    input  logic [63:0] mem_addr,
    input  logic [63:0] mem_wdata,
    input  logic [7:0]  mem_wmask,
    output logic        mem_ack,
    output logic [63:0] mem_rdata
);

    logic [31:0] rom [64];
    logic [63:0] ram [32];
    logic [31:0] lfsr = 32'h7dfa_58a5;
    logic [1:0]  i_ph;
    logic [1:0]  d_ph;
    logic [4:0]  i_cnt;
    logic [4:0]  d_cnt;
    logic [4:0]  dly;
    logic [63:0] line;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per delay bit
    task automatic pick_delay(output logic [4:0] d);
        int n;
        d = '0;
        n = slow ? 5 : 2;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            d = {d[3:0], lfsr[0]};
        end
    endtask

    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_ack  <= 1'b0;
            inst_data <= '0;
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            i_ph      <= 2'd0;
            d_ph      <= 2'd0;
            i_cnt     <= '0;
            d_cnt     <= '0;
            for (int i = 0; i < 32; i++) begin
                ram[i] <= {32'hd00d_0000 + 32'(i), 32'hbeef_0000 + 32'(i)};
            end
        end else begin
            case (i_ph) // instruction port
                2'd0: if (inst_req) begin
                    pick_delay(dly);
                    i_cnt <= dly;
                    i_ph  <= 2'd1;
                end
                2'd1: if (i_cnt == 0) begin
                    inst_data <= rom[inst_addr[7:2]];
                    inst_ack  <= 1'b1;
                    i_ph      <= 2'd2;
                end else begin
                    i_cnt <= i_cnt - 1'b1;
                end
                2'd2: if (!inst_req) begin
                    pick_delay(dly);
                    i_cnt <= dly;
                    i_ph  <= 2'd3;
                end
                default: if (i_cnt == 0) begin
                    inst_ack <= 1'b0;
                    i_ph     <= 2'd0;
                end else begin
                    i_cnt <= i_cnt - 1'b1;
                end
            endcase
            case (d_ph) // data port
                2'd0: if (mem_req) begin
                    pick_delay(dly);
                    d_cnt <= dly;
                    d_ph  <= 2'd1;
                end
                2'd1: if (d_cnt == 0) begin
                    line = ram[mem_addr[7:3]];
                    if (mem_we) begin
                        for (int b = 0; b < 8; b++) begin
                            if (mem_wmask[b]) line[8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                        ram[mem_addr[7:3]] <= line;
                    end
                    mem_rdata <= line;
                    mem_ack   <= 1'b1;
                    d_ph      <= 2'd2;
                end else begin
                    d_cnt <= d_cnt - 1'b1;
                end
                2'd2: if (!mem_req) begin
                    pick_delay(dly);
                    d_cnt <= dly;
                    d_ph  <= 2'd3;
                end
                default: if (d_cnt == 0) begin
                    mem_ack <= 1'b0;
                    d_ph    <= 2'd0;
                end else begin
                    d_cnt <= d_cnt - 1'b1;
                end
            endcase
        end
    end

endmodule

/* tests/tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core
    import rv_isa_pkg::*;
;

    localparam logic [63:0] RESET_PC = 64'h1000; // rom decodes address bits 7:2 only

    logic        clk;
    logic        rst_n;
    logic        rerun;
    logic        slow;
    logic        inst_req;
    logic [63:0] inst_addr;
    logic [31:0] inst_data;
    logic        inst_ack;
    logic        mem_req;
    logic        mem_we;
    logic [63:0] mem_addr;
    logic [63:0] mem_wdata;
    logic [7:0]  mem_wmask;
    logic        mem_ack;
    logic [63:0] mem_rdata;
    logic [4:0]  dbg_addr;
    logic [63:0] dbg_data;
    logic        dbg_chk;
    logic        retire;
    logic        halted;

    logic [31:0] prog [64];
    logic [63:0] exp_reg [32];
    logic [63:0] shadow [32];
    logic [63:0] exp_addr [32];
    logic [63:0] exp_data [32];
    logic [7:0]  exp_mask [32];
    int          exp_test [32];
    int          prog_len;
    int          n_inst;
    int          n_store;
    int          fetch_cnt;
    int          store_idx;
    int          retire_cnt;
    int          errs [1:6];
    string       names [1:6];
    bit          run2;
    bit          timed_out;
    int          n_fail;

    tb_clock clk0 (
        .rerun (rerun),
        .clk   (clk),
        .rst_n (rst_n)
    );

    tb_mem_model mem0 (
        .clk (clk), .rst_n (rst_n), .slow (slow),
        .inst_req (inst_req), .inst_addr (inst_addr), .inst_data (inst_data),
        .inst_ack (inst_ack), .mem_req (mem_req), .mem_we (mem_we),
        .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_wmask (mem_wmask),
        .mem_ack (mem_ack), .mem_rdata (mem_rdata)
    );

    rv_core_top #(
        .REG_COUNT (32),
        .RESET_PC  (RESET_PC)
    ) dut0 (
        .clk (clk), .rst_n (rst_n),
        .inst_req (inst_req), .inst_addr (inst_addr), .inst_data (inst_data),
        .inst_ack (inst_ack), .mem_req (mem_req), .mem_we (mem_we),
        .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_wmask (mem_wmask),
        .mem_ack (mem_ack), .mem_rdata (mem_rdata), .dbg_addr (dbg_addr),
        .dbg_data (dbg_data), .retire (retire), .halted (halted)
    );

    task automatic flag(input int t);
        if (run2) errs[6]++;
        else errs[t]++;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cnt  <= 0;
            store_idx  <= 0;
            retire_cnt <= 0;
        end else begin
            if (inst_req && inst_ack) fetch_cnt <= fetch_cnt + 1;
            if (mem_req && mem_ack && mem_we) store_idx <= store_idx + 1;
            if (retire) retire_cnt <= retire_cnt + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !inst_req && !mem_req && !retire && !halted)
        else begin
            $display("outputs of the core are active during reset");
            flag(1);
        end

    a_first_pc: assert property (@(posedge clk) disable iff (!rst_n)
        inst_req && fetch_cnt == 0 |-> inst_addr == RESET_PC)
        else begin
            $display("Error %s: expected %h actual %h", names[1], RESET_PC, inst_addr);
            flag(1);
        end

    a_store: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && mem_ack && mem_we |-> store_idx < n_store
        && mem_addr == exp_addr[store_idx[4:0]]
        && mem_wdata == exp_data[store_idx[4:0]] && mem_wmask == exp_mask[store_idx[4:0]])
        else begin
            int k;
            k = $sampled(store_idx);
            $display("Error %s: store %0d expected %h/%h/%h actual %h/%h/%h",
                names[run2 ? 6 : exp_test[k[4:0]]], k,
                exp_addr[k[4:0]], exp_data[k[4:0]], exp_mask[k[4:0]],
                mem_addr, mem_wdata, mem_wmask);
            flag(exp_test[k[4:0]]);
        end

    a_dbg: assert property (@(posedge clk) dbg_chk |-> dbg_data == exp_reg[dbg_addr])
        else begin
            $display("Error %s: x%0d expected %h actual %h", names[5], dbg_addr,
                exp_reg[dbg_addr], dbg_data);
            flag(5);
        end

    a_halt_quiet: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !inst_req)
        else begin
            $display("the core fetched again after it halted");
            flag(5);
        end

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic set_reg(input int rd, input logic [63:0] v);
        if (rd != 0) exp_reg[rd] = v; // x0 never changes
    endtask

    task automatic op_imm(input logic [2:0] f3, input int rd, input int rs1,
                          input logic [11:0] imm, input bit word);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        a = exp_reg[rs1];
        b = {{52{imm[11]}}, imm};
        case (f3)
            F3_XOR:  r = a ^ b;
            F3_OR:   r = a | b;
            F3_AND:  r = a & b;
            default: r = a + b;
        endcase
        if (word) r = {{32{r[31]}}, r[31:0]};
        emit({imm, 5'(rs1), f3, 5'(rd), word ? OPC_OP_IMM_32 : OPC_OP_IMM});
        set_reg(rd, r);
    endtask

    task automatic op_reg(input bit sub, input logic [2:0] f3, input int rd,
                          input int rs1, input int rs2, input bit word);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        a = exp_reg[rs1];
        b = exp_reg[rs2];
        case (f3)
            F3_XOR:  r = a ^ b;
            F3_OR:   r = a | b;
            F3_AND:  r = a & b;
            default: r = sub ? a - b : a + b;
        endcase
        if (word) r = {{32{r[31]}}, r[31:0]};
        emit({sub ? F7_SUB : F7_BASE, 5'(rs2), 5'(rs1), f3, 5'(rd),
              word ? OPC_OP_32 : OPC_OP});
        set_reg(rd, r);
    endtask

    task automatic lui(input int rd, input logic [19:0] imm);
        emit({imm, 5'(rd), OPC_LUI});
        set_reg(rd, {{32{imm[19]}}, imm, 12'b0});
    endtask

    // base register is always x0, so the offset is the address
    task automatic store(input logic [2:0] f3, input int rs2, input logic [11:0] ofs,
                         input int test);
        logic [7:0]  mask;
        logic [63:0] data;
        case (f3)
            F3_MEM_B: mask = 8'h01 << ofs[2:0];
            F3_MEM_W: mask = 8'h0f << ofs[2:0];
            default:  mask = 8'hff;
        endcase
        data = exp_reg[rs2] << {ofs[2:0], 3'b000};
        emit({ofs[11:5], 5'(rs2), 5'd0, f3, ofs[4:0], OPC_STORE});
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) shadow[ofs[7:3]][8*b +: 8] = data[8*b +: 8];
        end
        exp_addr[n_store] = {{52{ofs[11]}}, ofs[11:3], 3'b000}; // doubleword aligned
        exp_data[n_store] = data;
        exp_mask[n_store] = mask;
        exp_test[n_store] = test;
        n_store++;
    endtask

    task automatic load(input logic [2:0] f3, input int rd, input logic [11:0] ofs);
        logic [63:0] w;
        w = shadow[ofs[7:3]] >> {ofs[2:0], 3'b000};
        case (f3)
            F3_MEM_W:  w = {{32{w[31]}}, w[31:0]};
            F3_MEM_WU: w = {32'b0, w[31:0]};
            default:   w = w;
        endcase
        emit({ofs, 5'd0, f3, 5'(rd), OPC_LOAD});
        set_reg(rd, w);
    endtask

    task automatic build_program();
        for (int i = 0; i < 32; i++) begin
            exp_reg[i] = '0;
            shadow[i]  = {32'hd00d_0000 + 32'(i), 32'hbeef_0000 + 32'(i)};
        end
        op_imm(F3_ADD_SUB, 1, 0, 12'h123, 0);
        op_imm(F3_ADD_SUB, 2, 0, 12'hffb, 0); // -5
        lui(3, 20'h80001);
        op_reg(0, F3_ADD_SUB, 4, 1, 2, 0);
        op_reg(1, F3_ADD_SUB, 5, 1, 2, 0);
        op_reg(0, F3_AND, 6, 3, 2, 0);
        op_reg(0, F3_OR, 7, 1, 3, 0);
        op_reg(0, F3_XOR, 8, 2, 3, 0);
        op_imm(F3_AND, 9, 7, 12'h0f0, 0);
        op_imm(F3_OR, 10, 1, 12'hf00, 0);
        op_imm(F3_XOR, 11, 2, 12'h555, 0);
        op_imm(F3_ADD_SUB, 0, 1, 12'h007, 0);
        for (int r = 1; r <= 11; r++) store(F3_MEM_D, r, 12'(r * 8), 2);
        op_imm(F3_ADD_SUB, 12, 1, 12'he00, 1); // negative word
        op_reg(0, F3_ADD_SUB, 13, 3, 3, 1);    // wraps
        store(F3_MEM_W, 3, 12'h0a4, 3);
        load(F3_MEM_W, 14, 12'h0a4);
        load(F3_MEM_WU, 15, 12'h0a4);
        load(F3_MEM_D, 16, 12'h008);
        for (int r = 12; r <= 16; r++) store(F3_MEM_D, r, 12'(r * 8), 3);
        store(F3_MEM_B, 2, 12'h0c1, 4);
        store(F3_MEM_B, 1, 12'h0c7, 4);
        store(F3_MEM_W, 8, 12'h0c8, 4);
        store(F3_MEM_W, 11, 12'h0d4, 4);
        op_reg(0, F3_ADD_SUB, 0, 1, 2, 0);
        n_inst = prog_len;
        emit(32'hffff_ffff);
    endtask

    task automatic wait_rst(input logic level, input int limit, input int t);
        int n;
        n = 0;
        while (!timed_out && rst_n !== level) begin
            if (n == limit) begin
                $display("timeout waiting for the reset line");
                timed_out = 1'b1;
                flag(t);
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic wait_halt(input int limit, input int t);
        int n;
        n = 0;
        while (!timed_out && halted !== 1'b1) begin
            if (n == limit) begin
                $display("timeout waiting for the core to halt");
                timed_out = 1'b1;
                flag(t);
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic report(input int t);
        if (errs[t] == 0) $display("test %0d %s: ok", t, names[t]);
        else $display("test %0d %s: %0d errors", t, names[t], errs[t]);
    endtask

    initial begin
        rerun     = 1'b0;
        slow      = 1'b0;
        dbg_addr  = '0;
        dbg_chk   = 1'b0;
        run2      = 1'b0;
        timed_out = 1'b0;
        prog_len  = 0;
        n_store   = 0;
        names[1] = "reset";
        names[2] = "alu_ops";
        names[3] = "word_and_loads";
        names[4] = "narrow_stores";
        names[5] = "x0_debug_halt";
        names[6] = "back_pressure";
        for (int t = 1; t <= 6; t++) errs[t] = 0;
        for (int i = 0; i < 64; i++) prog[i] = '0;
        build_program();
        for (int i = 0; i < 64; i++) mem0.rom[i] = prog[i];

        wait_rst(1'b1, 100, 1);
        wait_halt(20000, 2);
        if (!timed_out) begin
            for (int t = 1; t <= 4; t++) report(t);
            for (int i = 0; i < 32; i++) begin
                @(negedge clk);
                dbg_addr = 5'(i);
                dbg_chk  = 1'b1;
            end
            @(negedge clk);
            dbg_chk = 1'b0;
            repeat (8) @(negedge clk); // halted core must stay quiet
            report(5);

            slow  = 1'b1; // long ack delays
            rerun = 1'b1;
            wait_rst(1'b0, 10, 6);
            run2  = 1'b1;
            rerun = 1'b0;
            wait_rst(1'b1, 100, 6);
            wait_halt(200000, 6);
        end
        if (!timed_out) begin
            assert (retire_cnt == n_inst && store_idx == n_store) else begin
                $display("Error %s: expected %0d/%0d actual %0d/%0d", names[6],
                    n_inst, n_store, retire_cnt, store_idx);
                errs[6]++;
            end
            report(6);
        end

        n_fail = 0;
        for (int t = 1; t <= 6; t++) begin
            if (errs[t] != 0) n_fail++;
        end
        $display("tests run 6, passed %0d, failed %0d", 6 - n_fail, n_fail);
        if (n_fail == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
